// ==== design/wb_pkg.sv ====
// ----------------------------------------------------------
// Writeback stage shared definitions
// ----------------------------------------------------------

package wb_pkg;

        // ----------------------------------------------------------
        // Types.
        // ----------------------------------------------------------

        // Data word or address.
        typedef logic [31:0] wb_word_t;
        // Status register image.
        typedef logic [31:0] wb_psr_t;
        // Physical register index.
        typedef logic [4:0]  wb_phys_idx_t;

        // ----------------------------------------------------------
        // Sizes and status register fields.
        // ----------------------------------------------------------

        localparam int WB_PHY_REGS     = 25;
        localparam int WB_PSR_MODE_LSB = 0;
        localparam int WB_PSR_MODE_MSB = 4;
        localparam int WB_PSR_T        = 5;
        localparam int WB_PSR_F        = 6;
        localparam int WB_PSR_I        = 7;

        // Physical register map. 0 to 15 are the user bank.
        localparam wb_phys_idx_t WB_ARCH_PC      = 5'd15;
        localparam wb_phys_idx_t WB_PHY_FIQ_R14  = 5'd16;
        localparam wb_phys_idx_t WB_PHY_FIQ_SPSR = 5'd17;
        localparam wb_phys_idx_t WB_PHY_IRQ_R14  = 5'd18;
        localparam wb_phys_idx_t WB_PHY_IRQ_SPSR = 5'd19;
        localparam wb_phys_idx_t WB_PHY_SVC_R14  = 5'd20;
        localparam wb_phys_idx_t WB_PHY_SVC_SPSR = 5'd21;
        localparam wb_phys_idx_t WB_PHY_UND_R14  = 5'd22;
        localparam wb_phys_idx_t WB_PHY_UND_SPSR = 5'd23;
        // Reads as zero, swallows writes.
        localparam wb_phys_idx_t WB_PHY_RAZ      = 5'd24;

        // Mode field codes.
        localparam logic [4:0] WB_MODE_USR = 5'h10;
        localparam logic [4:0] WB_MODE_FIQ = 5'h11;
        localparam logic [4:0] WB_MODE_IRQ = 5'h12;
        localparam logic [4:0] WB_MODE_SVC = 5'h13;
        localparam logic [4:0] WB_MODE_UND = 5'h1B;

        // Exception vectors.
        localparam wb_word_t WB_RESET_VECTOR = 32'h0;
        localparam wb_word_t WB_UND_VECTOR   = 32'h4;
        localparam wb_word_t WB_SWI_VECTOR   = 32'h8;
        localparam wb_word_t WB_IRQ_VECTOR   = 32'h18;
        localparam wb_word_t WB_FIQ_VECTOR   = 32'h1C;

        // Fetch step and post-redirect mask length.
        localparam wb_word_t WB_PC_STEP     = 32'd4;
        localparam int       WB_MASK_CYCLES = 3;

endpackage

// ==== design/wb_register_file.sv ====
// ----------------------------------------------------------
// Banked register file
// ----------------------------------------------------------

`timescale 1ns/1ps

module wb_register_file import wb_pkg::*;
(
        input  logic         i_clk,
        input  logic         i_reset,

        // Write side. Both ports share one enable.
        input  logic         i_wen,
        input  wb_phys_idx_t i_wr_addr_a,
        input  wb_phys_idx_t i_wr_addr_b,
        input  wb_word_t     i_wr_data_a,
        input  wb_word_t     i_wr_data_b,

        // Read side.
        input  wb_phys_idx_t i_rd_addr_a,
        input  wb_phys_idx_t i_rd_addr_b,
        output wb_word_t     o_rd_data_a,
        output wb_word_t     o_rd_data_b
);

wb_word_t regs_ff [WB_PHY_REGS];

// True for an index that holds real storage.
function automatic logic is_real (input wb_phys_idx_t idx);
        return (idx < WB_PHY_REGS) && (idx != WB_PHY_RAZ);
endfunction

// Reads straight from state, no bypass.
always_comb
begin
        o_rd_data_a = is_real(i_rd_addr_a) ? regs_ff[i_rd_addr_a] : '0;
        o_rd_data_b = is_real(i_rd_addr_b) ? regs_ff[i_rd_addr_b] : '0;
end

// Port b is assigned last, so it wins a tie.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < WB_PHY_REGS; i++)
                begin
                        regs_ff[i] <= '0;
                end
        end
        else if (i_wen)
        begin
                if (is_real(i_wr_addr_a))
                begin
                        regs_ff[i_wr_addr_a] <= i_wr_data_a;
                end
                if (is_real(i_wr_addr_b))
                begin
                        regs_ff[i_wr_addr_b] <= i_wr_data_b;
                end
        end
end

endmodule

// ==== design/wb_exception_ctrl.sv ====
// ----------------------------------------------------------
// Exception and retirement control
// ----------------------------------------------------------

`timescale 1ns/1ps

module wb_exception_ctrl import wb_pkg::*;
(
        input  logic         i_clk,
        input  logic         i_reset,

        // Retiring instruction.
        input  logic         i_valid,
        input  logic         i_mem_load,
        input  wb_phys_idx_t i_wr_index,
        input  wb_phys_idx_t i_wr_index_1,
        input  wb_word_t     i_wr_data,
        input  wb_word_t     i_wr_data_1,
        input  wb_psr_t      i_flags,

        // Qualified exception requests.
        input  logic         i_fiq,
        input  logic         i_irq,
        input  logic         i_swi,
        input  logic         i_und,

        // Register file write ports.
        output logic         o_wen,
        output wb_phys_idx_t o_wa_a,
        output wb_phys_idx_t o_wa_b,
        output wb_word_t     o_wd_a,
        output wb_word_t     o_wd_b,

        // Redirect request to the PC sequencer.
        output logic         o_redirect,
        output wb_word_t     o_redirect_pc,

        output logic         o_clear_from_writeback,
        output wb_psr_t      o_cpsr
);

wb_psr_t      cpsr_ff;
wb_psr_t      cpsr_nxt;
logic         exc_take;
logic [4:0]   exc_mode;
wb_phys_idx_t exc_r14;
wb_phys_idx_t exc_spsr;
wb_word_t     exc_vector;
logic         load_pc;

assign o_cpsr   = cpsr_ff;
assign exc_take = i_fiq | i_irq | i_swi | i_und;
// Only a memory load may write the PC here.
assign load_pc  = i_mem_load && (i_wr_index_1 == WB_ARCH_PC);

// ----------------------------------------------------------
// Banked targets of the winning exception.
// ----------------------------------------------------------

always_comb
begin
        // UND is the lowest, so it is the fallback.
        exc_mode   = WB_MODE_UND;
        exc_r14    = WB_PHY_UND_R14;
        exc_spsr   = WB_PHY_UND_SPSR;
        exc_vector = WB_UND_VECTOR;

        if (i_fiq)
        begin
                exc_mode   = WB_MODE_FIQ;
                exc_r14    = WB_PHY_FIQ_R14;
                exc_spsr   = WB_PHY_FIQ_SPSR;
                exc_vector = WB_FIQ_VECTOR;
        end
        else if (i_irq)
        begin
                exc_mode   = WB_MODE_IRQ;
                exc_r14    = WB_PHY_IRQ_R14;
                exc_spsr   = WB_PHY_IRQ_SPSR;
                exc_vector = WB_IRQ_VECTOR;
        end
        else if (i_swi)
        begin
                // SWI lands in supervisor mode.
                exc_mode   = WB_MODE_SVC;
                exc_r14    = WB_PHY_SVC_R14;
                exc_spsr   = WB_PHY_SVC_SPSR;
                exc_vector = WB_SWI_VECTOR;
        end
end

// ----------------------------------------------------------
// Priority tree. Exceptions ignore the code stall.
// ----------------------------------------------------------

always_comb
begin
        o_wen                  = 1'b0;
        o_wa_a                 = WB_PHY_RAZ;
        o_wa_b                 = WB_PHY_RAZ;
        o_wd_a                 = '0;
        o_wd_b                 = '0;
        o_redirect             = 1'b0;
        o_redirect_pc          = '0;
        o_clear_from_writeback = 1'b0;
        cpsr_nxt               = cpsr_ff;

        if (exc_take)
        begin
                // Link on port a, old status on port b.
                o_wen  = 1'b1;
                o_wa_a = exc_r14;
                o_wd_a = i_wr_data;
                o_wa_b = exc_spsr;
                o_wd_b = cpsr_ff;

                cpsr_nxt[WB_PSR_MODE_MSB:WB_PSR_MODE_LSB] = exc_mode;
                cpsr_nxt[WB_PSR_I] = 1'b1;
                cpsr_nxt[WB_PSR_T] = 1'b0;
                if (i_fiq)
                begin
                        cpsr_nxt[WB_PSR_F] = 1'b1;
                end

                o_redirect             = 1'b1;
                o_redirect_pc          = exc_vector;
                o_clear_from_writeback = 1'b1;
        end
        else if (i_valid)
        begin
                cpsr_nxt = i_flags;
                o_wen    = 1'b1;
                o_wa_a   = i_wr_index;
                o_wd_a   = i_wr_data;
                // Memory port is parked on RAZ unless loading.
                o_wa_b   = i_mem_load ? i_wr_index_1 : WB_PHY_RAZ;
                o_wd_b   = i_wr_data_1;

                if (load_pc)
                begin
                        o_redirect             = 1'b1;
                        o_redirect_pc          = i_wr_data_1;
                        o_clear_from_writeback = 1'b1;
                        // Bit 0 of the target picks ARM or Thumb.
                        cpsr_nxt[WB_PSR_T]     = i_wr_data_1[0];
                end
        end
end

// Reset into SVC with both interrupts masked.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                cpsr_ff                                  <= '0;
                cpsr_ff[WB_PSR_MODE_MSB:WB_PSR_MODE_LSB] <= WB_MODE_SVC;
                cpsr_ff[WB_PSR_I]                        <= 1'b1;
                cpsr_ff[WB_PSR_F]                        <= 1'b1;
        end
        else
        begin
                cpsr_ff <= cpsr_nxt;
        end
end

endmodule

// ==== design/wb_pc_sequencer.sv ====
// ----------------------------------------------------------
// Fetch PC sequencer
// ----------------------------------------------------------

`timescale 1ns/1ps

module wb_pc_sequencer import wb_pkg::*;
(
        input  logic     i_clk,
        input  logic     i_reset,
        input  logic     i_code_stall,

        // Redirect sources, highest priority first.
        input  logic     i_wb_redirect,
        input  wb_word_t i_wb_target,
        input  logic     i_clear_from_alu,
        input  wb_word_t i_pc_from_alu,
        input  logic     i_clear_from_decode,
        input  wb_word_t i_pc_from_decode,

        output wb_word_t o_pc_nxt,
        output wb_word_t o_pc_check,
        output wb_word_t o_pc,
        output logic     o_shelve,
        output logic     o_mask
);

wb_word_t                  pc_ff, pc_nxt;
wb_word_t                  del1_ff, del2_ff, del3_ff;
wb_word_t                  shelve_pc_ff, shelve_pc_nxt;
logic                      shelve_ff, shelve_nxt;
logic [WB_MASK_CYCLES-1:0] mask_ff, mask_nxt;
logic                      take;
wb_word_t                  take_pc;
logic                      shift;

assign o_pc_nxt   = pc_ff;
assign o_pc_check = del2_ff;
assign o_pc       = del3_ff;
assign o_shelve   = shelve_ff;
// One bit walks through the mask, high while it is inside.
assign o_mask     = |mask_ff;

// Pick the winning redirect.
always_comb
begin
        take    = 1'b1;
        take_pc = i_wb_target;
        if (i_wb_redirect)
                take_pc = i_wb_target;
        else if (i_clear_from_alu)
                take_pc = i_pc_from_alu;
        else if (i_clear_from_decode)
                take_pc = i_pc_from_decode;
        else
                take = 1'b0;
end

// ----------------------------------------------------------
// Next PC, shelving and mask.
// ----------------------------------------------------------

always_comb
begin
        pc_nxt        = pc_ff;
        shelve_nxt    = shelve_ff;
        shelve_pc_nxt = shelve_pc_ff;
        mask_nxt      = mask_ff << 1;
        shift         = 1'b0;

        if (take && !i_code_stall)
        begin
                pc_nxt      = take_pc;
                shift       = 1'b1;
                shelve_nxt  = 1'b0;
                mask_nxt    = '0;
                mask_nxt[0] = 1'b1;
        end
        else if (take)
        begin
                // Park the target until the stall lifts.
                shelve_nxt    = 1'b1;
                shelve_pc_nxt = take_pc;
        end
        else if (i_code_stall)
        begin
                // Hold everything.
                pc_nxt = pc_ff;
        end
        else if (shelve_ff)
        begin
                // Delay line stays put here.
                pc_nxt      = shelve_pc_ff;
                shelve_nxt  = 1'b0;
                mask_nxt    = '0;
                mask_nxt[0] = 1'b1;
        end
        else
        begin
                pc_nxt = pc_ff + WB_PC_STEP;
                shift  = 1'b1;
        end

        // Halfword aligned always.
        pc_nxt[0] = 1'b0;
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                pc_ff     <= '0;
                del1_ff   <= '0;
                del2_ff   <= '0;
                del3_ff   <= '0;
                shelve_ff <= 1'b0;
                mask_ff   <= '0;
        end
        else
        begin
                pc_ff     <= pc_nxt;
                shelve_ff <= shelve_nxt;
                mask_ff   <= mask_nxt;
                if (shift)
                begin
                        del1_ff <= pc_ff;
                        del2_ff <= del1_ff;
                        del3_ff <= del2_ff;
                end
        end
end

// Shelved target is payload only.
always_ff @(posedge i_clk)
begin
        shelve_pc_ff <= shelve_pc_nxt;
end

endmodule

// ==== design/wb_top.sv ====
// ----------------------------------------------------------
// Writeback stage top level
// ----------------------------------------------------------

`timescale 1ns/1ps

module wb_top import wb_pkg::*;
(
        input  logic         i_clk,
        input  logic         i_reset,

        // PC control from other units.
        input  logic         i_code_stall,
        input  logic         i_clear_from_alu,
        input  wb_word_t     i_pc_from_alu,
        input  logic         i_clear_from_decode,
        input  wb_word_t     i_pc_from_decode,

        // Retirement.
        input  logic         i_valid,
        input  logic         i_mem_load,
        input  wb_phys_idx_t i_wr_index,
        input  wb_word_t     i_wr_data,
        input  wb_phys_idx_t i_wr_index_1,
        input  wb_word_t     i_wr_data_1,
        input  wb_psr_t      i_flags,

        // Exceptions.
        input  logic         i_fiq,
        input  logic         i_irq,
        input  logic         i_swi,
        input  logic         i_und,

        // Register reads.
        input  wb_phys_idx_t i_rd_index_0,
        input  wb_phys_idx_t i_rd_index_1,
        output wb_word_t     o_rd_data_0,
        output wb_word_t     o_rd_data_1,

        output wb_word_t     o_pc_nxt,
        output wb_word_t     o_pc_check,
        output wb_word_t     o_pc,
        output logic         o_shelve,
        output logic         o_mask,
        output logic         o_clear_from_writeback,
        output wb_psr_t      o_cpsr
);

logic         wen;
wb_phys_idx_t wa_a, wa_b;
wb_word_t     wd_a, wd_b;
logic         wb_redirect;
wb_word_t     wb_target;

wb_register_file u_register_file
(
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wen       (wen),
        .i_wr_addr_a (wa_a),
        .i_wr_addr_b (wa_b),
        .i_wr_data_a (wd_a),
        .i_wr_data_b (wd_b),
        .i_rd_addr_a (i_rd_index_0),
        .i_rd_addr_b (i_rd_index_1),
        .o_rd_data_a (o_rd_data_0),
        .o_rd_data_b (o_rd_data_1)
);

wb_exception_ctrl u_exception_ctrl
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_valid                (i_valid),
        .i_mem_load             (i_mem_load),
        .i_wr_index             (i_wr_index),
        .i_wr_index_1           (i_wr_index_1),
        .i_wr_data              (i_wr_data),
        .i_wr_data_1            (i_wr_data_1),
        .i_flags                (i_flags),
        .i_fiq                  (i_fiq),
        .i_irq                  (i_irq),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .o_wen                  (wen),
        .o_wa_a                 (wa_a),
        .o_wa_b                 (wa_b),
        .o_wd_a                 (wd_a),
        .o_wd_b                 (wd_b),
        .o_redirect             (wb_redirect),
        .o_redirect_pc          (wb_target),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_cpsr                 (o_cpsr)
);

wb_pc_sequencer u_pc_sequencer
(
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_code_stall        (i_code_stall),
        .i_wb_redirect       (wb_redirect),
        .i_wb_target         (wb_target),
        .i_clear_from_alu    (i_clear_from_alu),
        .i_pc_from_alu       (i_pc_from_alu),
        .i_clear_from_decode (i_clear_from_decode),
        .i_pc_from_decode    (i_pc_from_decode),
        .o_pc_nxt            (o_pc_nxt),
        .o_pc_check          (o_pc_check),
        .o_pc                (o_pc),
        .o_shelve            (o_shelve),
        .o_mask              (o_mask)
);

endmodule

// ==== sim/wb_props.sv ====
// ----------------------------------------------------------
// Writeback stage assertions
// ----------------------------------------------------------

`timescale 1ns/1ps

module wb_props import wb_pkg::*;
(
        input logic     i_clk,
        input logic     i_reset,
        input logic     i_code_stall,
        input logic     i_clear_from_alu,
        input logic     i_clear_from_decode,
        input logic     i_fiq,
        input logic     i_irq,
        input logic     i_swi,
        input logic     i_und,
        input wb_word_t o_pc_nxt,
        input logic     o_shelve,
        input logic     o_mask,
        input logic     o_clear_from_writeback,
        input wb_psr_t  o_cpsr
);

logic mask_load;
logic exc_any;
// Number of failed assertions so far.
int   fail_count = 0;

// Any event that restarts the mask this cycle.
assign mask_load = !i_code_stall &&
                   (o_clear_from_writeback || i_clear_from_alu || i_clear_from_decode || o_shelve);
assign exc_any   = i_fiq | i_irq | i_swi | i_und;

// Fetch PC stays halfword aligned.
a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset) !o_pc_nxt[0])
        else
        begin
                $error("o_pc_nxt bit 0 set");
                fail_count++;
        end

a_clear_masks: assert property (@(posedge i_clk) disable iff (i_reset)
        o_clear_from_writeback && !i_code_stall |=> o_mask)
        else
        begin
                $error("Writeback redirect not followed by o_mask");
                fail_count++;
        end

// Three cycles at most without a reload.
a_mask_len: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_mask && !mask_load) ##1 !mask_load ##1 !mask_load |=> !o_mask)
        else
        begin
                $error("o_mask high four cycles without a new redirect");
                fail_count++;
        end

a_exc_irq_off: assert property (@(posedge i_clk) disable iff (i_reset)
        exc_any |=> o_cpsr[WB_PSR_I])
        else
        begin
                $error("CPSR I bit clear after exception entry");
                fail_count++;
        end

endmodule

bind wb_top wb_props u_props
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_code_stall           (i_code_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_fiq                  (i_fiq),
        .i_irq                  (i_irq),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .o_pc_nxt               (o_pc_nxt),
        .o_shelve               (o_shelve),
        .o_mask                 (o_mask),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_cpsr                 (o_cpsr)
);

// ==== sim/wb_tb.sv ====
// ----------------------------------------------------------
// Writeback stage testbench
// ----------------------------------------------------------

`timescale 1ns/1ps

module wb_tb import wb_pkg::*;
();

localparam int NUM_CYCLES  = 3000;
localparam int DRAIN_LIMIT = 8;

// DUT inputs.
logic         i_clk;
logic         i_reset;
logic         i_code_stall;
logic         i_clear_from_alu;
wb_word_t     i_pc_from_alu;
logic         i_clear_from_decode;
wb_word_t     i_pc_from_decode;
logic         i_valid;
logic         i_mem_load;
wb_phys_idx_t i_wr_index;
wb_word_t     i_wr_data;
wb_phys_idx_t i_wr_index_1;
wb_word_t     i_wr_data_1;
wb_psr_t      i_flags;
logic         i_fiq;
logic         i_irq;
logic         i_swi;
logic         i_und;
wb_phys_idx_t i_rd_index_0;
wb_phys_idx_t i_rd_index_1;

// DUT outputs.
wb_word_t     o_rd_data_0;
wb_word_t     o_rd_data_1;
wb_word_t     o_pc_nxt;
wb_word_t     o_pc_check;
wb_word_t     o_pc;
logic         o_shelve;
logic         o_mask;
logic         o_clear_from_writeback;
wb_psr_t      o_cpsr;

// ----------------------------------------------------------
// Reference model state.
// ----------------------------------------------------------

wb_word_t     m_pc;
wb_word_t     m_d1;
wb_word_t     m_d2;
wb_word_t     m_d3;
wb_word_t     m_shelve_pc;
logic         m_shelve;
int           m_mask_cnt;
wb_psr_t      m_cpsr;
wb_word_t     m_regs [WB_PHY_REGS];

logic [31:0]  lfsr_state = 32'h1c60ffed;
int           errors     = 0;
int           drain      = 0;

wb_top i_wb_top
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_code_stall           (i_code_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_from_decode       (i_pc_from_decode),
        .i_valid                (i_valid),
        .i_mem_load             (i_mem_load),
        .i_wr_index             (i_wr_index),
        .i_wr_data              (i_wr_data),
        .i_wr_index_1           (i_wr_index_1),
        .i_wr_data_1            (i_wr_data_1),
        .i_flags                (i_flags),
        .i_fiq                  (i_fiq),
        .i_irq                  (i_irq),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .i_rd_index_0           (i_rd_index_0),
        .i_rd_index_1           (i_rd_index_1),
        .o_rd_data_0            (o_rd_data_0),
        .o_rd_data_1            (o_rd_data_1),
        .o_pc_nxt               (o_pc_nxt),
        .o_pc_check             (o_pc_check),
        .o_pc                   (o_pc),
        .o_shelve               (o_shelve),
        .o_mask                 (o_mask),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_cpsr                 (o_cpsr)
);

// 8 ns period.
always #4 i_clk = ~i_clk;

// ----------------------------------------------------------
// Random source. Fibonacci LFSR, taps 32 22 2 1.
// ----------------------------------------------------------

function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
                lfsr_state = {lfsr_state[30:0],
                              lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
                r = {r[30:0], lfsr_state[0]};
        end
        return r;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                errors++;
                $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
endtask

// Idle bus, no redirect and no retirement.
task automatic drive_quiet();
        i_code_stall        = 1'b0;
        i_clear_from_alu    = 1'b0;
        i_pc_from_alu       = '0;
        i_clear_from_decode = 1'b0;
        i_pc_from_decode    = '0;
        i_valid             = 1'b0;
        i_mem_load          = 1'b0;
        i_wr_index          = '0;
        i_wr_data           = '0;
        i_wr_index_1        = '0;
        i_wr_data_1         = '0;
        i_flags             = '0;
        i_fiq               = 1'b0;
        i_irq               = 1'b0;
        i_swi               = 1'b0;
        i_und               = 1'b0;
        i_rd_index_0        = '0;
        i_rd_index_1        = '0;
endtask

task automatic drive_random();
        i_code_stall        = rand_bits(2) == 0;
        i_clear_from_alu    = rand_bits(3) == 0;
        i_pc_from_alu       = rand_bits(32);
        i_clear_from_decode = rand_bits(3) == 0;
        i_pc_from_decode    = rand_bits(32);
        i_valid             = rand_bits(1);
        i_mem_load          = rand_bits(1);
        i_wr_index          = rand_bits(5) % WB_PHY_REGS;
        // Bias the load port toward the PC.
        i_wr_index_1        = (rand_bits(3) == 0) ? WB_ARCH_PC : rand_bits(5) % WB_PHY_REGS;
        i_wr_data           = rand_bits(32);
        i_wr_data_1         = rand_bits(32);
        i_flags             = rand_bits(32);
        // Exceptions are rare, 1 in 32 each.
        i_fiq               = rand_bits(5) == 0;
        i_irq               = rand_bits(5) == 0;
        i_swi               = rand_bits(5) == 0;
        i_und               = rand_bits(5) == 0;
        i_rd_index_0        = rand_bits(5) % WB_PHY_REGS;
        i_rd_index_1        = rand_bits(5) % WB_PHY_REGS;
endtask

// ----------------------------------------------------------
// Model.
// ----------------------------------------------------------

task automatic model_reset();
        for (int k = 0; k < WB_PHY_REGS; k++)
        begin
                m_regs[k] = '0;
        end
        m_pc        = '0;
        m_d1        = '0;
        m_d2        = '0;
        m_d3        = '0;
        m_shelve    = 1'b0;
        m_shelve_pc = '0;
        m_mask_cnt  = 0;
        // SVC mode, both interrupts masked.
        m_cpsr                                  = '0;
        m_cpsr[WB_PSR_MODE_MSB:WB_PSR_MODE_LSB] = WB_MODE_SVC;
        m_cpsr[WB_PSR_I]                        = 1'b1;
        m_cpsr[WB_PSR_F]                        = 1'b1;
endtask

task automatic write_reg(input wb_phys_idx_t idx, input wb_word_t data);
        if (idx != WB_PHY_RAZ)
        begin
                m_regs[idx] = data;
        end
endtask

function automatic wb_word_t read_model(input wb_phys_idx_t idx);
        return (idx == WB_PHY_RAZ) ? '0 : m_regs[idx];
endfunction

task automatic shift_delay();
        m_d3 = m_d2;
        m_d2 = m_d1;
        m_d1 = m_pc;
endtask

// One rising edge of the model.
task automatic model_step();
        logic         exc;
        logic         load_pc;
        logic         take;
        wb_word_t     tpc;
        wb_word_t     vec;
        logic [4:0]   mode;
        wb_phys_idx_t r14;
        wb_phys_idx_t spsr;
        wb_psr_t      old_cpsr;

        exc      = i_fiq | i_irq | i_swi | i_und;
        load_pc  = !exc && i_valid && i_mem_load && (i_wr_index_1 == WB_ARCH_PC);
        old_cpsr = m_cpsr;

        // Exception priority FIQ, IRQ, SWI, UND.
        if (i_fiq)
        begin
                mode = WB_MODE_FIQ;
                r14  = WB_PHY_FIQ_R14;
                spsr = WB_PHY_FIQ_SPSR;
                vec  = WB_FIQ_VECTOR;
        end
        else if (i_irq)
        begin
                mode = WB_MODE_IRQ;
                r14  = WB_PHY_IRQ_R14;
                spsr = WB_PHY_IRQ_SPSR;
                vec  = WB_IRQ_VECTOR;
        end
        else if (i_swi)
        begin
                mode = WB_MODE_SVC;
                r14  = WB_PHY_SVC_R14;
                spsr = WB_PHY_SVC_SPSR;
                vec  = WB_SWI_VECTOR;
        end
        else
        begin
                mode = WB_MODE_UND;
                r14  = WB_PHY_UND_R14;
                spsr = WB_PHY_UND_SPSR;
                vec  = WB_UND_VECTOR;
        end

        // Status and register writes.
        if (exc)
        begin
                write_reg(r14, i_wr_data);
                write_reg(spsr, old_cpsr);
                m_cpsr[WB_PSR_MODE_MSB:WB_PSR_MODE_LSB] = mode;
                m_cpsr[WB_PSR_I]                        = 1'b1;
                m_cpsr[WB_PSR_T]                        = 1'b0;
                if (i_fiq)
                begin
                        m_cpsr[WB_PSR_F] = 1'b1;
                end
        end
        else if (i_valid)
        begin
                // Port b second, it wins a tie.
                write_reg(i_wr_index, i_wr_data);
                if (i_mem_load)
                begin
                        write_reg(i_wr_index_1, i_wr_data_1);
                end
                m_cpsr = i_flags;
                if (load_pc)
                begin
                        m_cpsr[WB_PSR_T] = i_wr_data_1[0];
                end
        end

        // Redirect source.
        take = 1'b1;
        if (exc)
                tpc = vec;
        else if (load_pc)
                tpc = i_wr_data_1;
        else if (i_clear_from_alu)
                tpc = i_pc_from_alu;
        else if (i_clear_from_decode)
                tpc = i_pc_from_decode;
        else
        begin
                take = 1'b0;
                tpc  = '0;
        end

        if (m_mask_cnt > 0)
        begin
                m_mask_cnt--;
        end

        // Fetch PC.
        if (take && !i_code_stall)
        begin
                shift_delay();
                m_pc       = tpc & ~32'h1;
                m_shelve   = 1'b0;
                m_mask_cnt = WB_MASK_CYCLES;
        end
        else if (take)
        begin
                m_shelve    = 1'b1;
                m_shelve_pc = tpc;
        end
        else if (i_code_stall)
        begin
                // Hold.
                m_pc = m_pc;
        end
        else if (m_shelve)
        begin
                // Shelved target, delay line does not move.
                m_pc       = m_shelve_pc & ~32'h1;
                m_shelve   = 1'b0;
                m_mask_cnt = WB_MASK_CYCLES;
        end
        else
        begin
                shift_delay();
                m_pc = m_pc + WB_PC_STEP;
        end
endtask

task automatic check_outputs();
        check_value("o_pc_nxt", o_pc_nxt, m_pc);
        check_value("o_pc_check", o_pc_check, m_d2);
        check_value("o_pc", o_pc, m_d3);
        check_value("o_shelve", o_shelve, m_shelve);
        check_value("o_mask", o_mask, m_mask_cnt != 0);
        check_value("o_cpsr", o_cpsr, m_cpsr);
        check_value("o_rd_data_0", o_rd_data_0, read_model(i_rd_index_0));
        check_value("o_rd_data_1", o_rd_data_1, read_model(i_rd_index_1));
endtask

// Starts and ends on a falling edge.
task automatic run_cycle(input logic quiet);
        logic exp_clear;

        if (quiet)
                drive_quiet();
        else
                drive_random();
        #1;
        exp_clear = i_fiq | i_irq | i_swi | i_und |
                    (i_valid & i_mem_load & (i_wr_index_1 == WB_ARCH_PC));
        check_value("o_clear_from_writeback", o_clear_from_writeback, exp_clear);
        @(posedge i_clk);
        model_step();
        #1;
        check_outputs();
        @(negedge i_clk);
endtask

// ----------------------------------------------------------
// Main sequence.
// ----------------------------------------------------------

initial
begin
        i_clk   = 1'b0;
        i_reset = 1'b1;
        drive_quiet();
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);

        // Reset values.
        model_reset();
        check_outputs();
        check_value("o_clear_from_writeback", o_clear_from_writeback, 1'b0);
        i_reset = 1'b0;

        for (int n = 0; n < NUM_CYCLES; n++)
        begin
                run_cycle(1'b0);
        end

        // Quiet bus, then wait for the mask to clear.
        run_cycle(1'b1);
        while (o_mask && drain < DRAIN_LIMIT)
        begin
                run_cycle(1'b1);
                drain++;
        end
        if (o_mask)
        begin
                errors++;
                $display("Timeout: o_mask still high %0d cycles after redirects stopped",
                         DRAIN_LIMIT);
        end

        $display("Checks done, errors: %0d, assertion failures: %0d",
                 errors, i_wb_top.u_props.fail_count);
        if (errors == 0 && i_wb_top.u_props.fail_count == 0)
                $display("TEST RESULT: PASS");
        else
                $display("TEST RESULT: FAIL");
        $finish;
end

endmodule

// ==== files.f ====
design/wb_pkg.sv
design/wb_register_file.sv
design/wb_exception_ctrl.sv
design/wb_pc_sequencer.sv
design/wb_top.sv
sim/wb_props.sv
sim/wb_tb.sv
